// File: hdl/histPkg.sv
package histPkg;

    // rough timestamp width in ticks
    localparam int TS_WIDTH = 10;
    // 16 bins per histogram
    localparam int BIN_BITS = 4;
    localparam int NUM_BINS = 1 << BIN_BITS;
    // coarse bin is 64 ticks wide
    localparam int COARSE_SHIFT = TS_WIDTH - BIN_BITS;

    typedef logic [TS_WIDTH-1:0] ts_t;
    typedef logic [BIN_BITS-1:0] binIdx_t;

    // pass sequencing, one value per stage of the acquisition
    typedef enum logic [2:0] {
        IDLE,
        COARSE,
        COARSE_PEAK,
        FINE,
        FINE_PEAK,
        DONE
    } hisPhase_t;

    // filtered event handed from the filter to the builder
    typedef struct packed {
        logic    valid;
        logic    inWindow;
        binIdx_t bin;
    } binEvent_t;

    // word delivered over the result port
    typedef struct packed {
        binIdx_t     coarsePeak;
        binIdx_t     finePeak;
        logic [15:0] fineCount;
        // in ticks, zero-extended
        logic [15:0] peakTime;
    } hisResult_t;

endpackage

// File: hdl/ctrlPkg.sv
package ctrlPkg;

    // register map
    localparam logic [1:0] REG_ACQ_LEN    = 2'd0;
    localparam logic [1:0] REG_FINE_SHIFT = 2'd1;
    localparam logic [1:0] REG_START      = 2'd2;

    // values after reset
    localparam logic [15:0] ACQ_LEN_RESET    = 16'd32;
    localparam logic [1:0]  FINE_SHIFT_RESET = 2'd0;

    // one write on the config port
    typedef struct packed {
        logic [1:0]  addr;
        logic [15:0] data;
    } cfgWrite_t;

    // live settings seen by the datapath
    typedef struct packed {
        // events per pass
        logic [15:0] acqLength;
        // fine bin is 2**fineShift ticks
        logic [1:0]  fineShift;
    } hisCfg_t;

endpackage

// File: hdl/hisConfig.sv
`timescale 1ns/10ps

module hisConfig (
    input  logic               clk,
    input  logic               rstN,
    input  logic               cfgReq,
    input  ctrlPkg::cfgWrite_t cfgWord,
    output logic               cfgAck,
    output ctrlPkg::hisCfg_t   cfg,
    output logic               startPulse
);
    import ctrlPkg::*;

    // new request not yet acknowledged
    logic wrAccept;
    // master has let go of req
    logic wrRelease;

    assign wrAccept  = cfgReq && !cfgAck;
    assign wrRelease = !cfgReq && cfgAck;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            cfgAck        <= 1'b0;
            cfg.acqLength <= ACQ_LEN_RESET;
            cfg.fineShift <= FINE_SHIFT_RESET;
            startPulse    <= 1'b0;
        end else begin
            // start is a strobe and never held
            startPulse <= 1'b0;
            if (wrAccept) begin
                // register and ack change on the same edge
                cfgAck <= 1'b1;
                case (cfgWord.addr)
                    REG_ACQ_LEN: begin
                        cfg.acqLength <= cfgWord.data;
                    end
                    REG_FINE_SHIFT: begin
                        // only the low two bits are kept
                        cfg.fineShift <= cfgWord.data[1:0];
                    end
                    REG_START: begin
                        // any write starts regardless of data
                        startPulse <= 1'b1;
                    end
                    default: begin
                        // unmapped address only gets the ack
                    end
                endcase
            end else if (wrRelease) begin
                // closes the four-phase cycle
                cfgAck <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/dataFilter.sv
`timescale 1ns/10ps

module dataFilter (
    input  logic               clk,
    input  logic               rstN,
    input  histPkg::ts_t       roughData,
    input  logic               wrEn,
    input  histPkg::hisPhase_t phase,
    input  ctrlPkg::hisCfg_t   cfg,
    input  histPkg::binIdx_t   peakBin,
    input  logic               peakDone,
    output histPkg::binEvent_t binEvent
);
    import histPkg::*;

    // lower edge of the fine window
    ts_t        thMinus;
    logic [1:0] winShift;
    ts_t        offset;
    ts_t        winSpan;
    logic       inRange;
    binIdx_t    coarseBin;
    binIdx_t    fineBin;
    binIdx_t    nextBin;
    logic       nextIn;
    logic       inPass;

    assign inPass = (phase == COARSE) || (phase == FINE);

    // top bits select the wide bin
    assign coarseBin = binIdx_t'(roughData >> COARSE_SHIFT);

    // distance above the window edge
    assign offset  = roughData - thMinus;
    // 16 fine bins
    assign winSpan = ts_t'(NUM_BINS) << winShift;
    // below-edge stamps wrap, so check the raw compare too
    assign inRange = (roughData >= thMinus) && (offset < winSpan);
    assign fineBin = binIdx_t'(offset >> winShift);

    always_comb begin
        if (phase == FINE) begin
            nextBin = fineBin;
            nextIn  = inRange;
        end else begin
            // coarse pass takes everything
            nextBin = coarseBin;
            nextIn  = 1'b1;
        end
    end

    // window follows the coarse peak
    always_ff @(posedge clk) begin
        if (!rstN) begin
            thMinus  <= '0;
            winShift <= '0;
        end else if (peakDone && (phase == COARSE_PEAK)) begin
            thMinus  <= ts_t'({peakBin, {COARSE_SHIFT{1'b0}}});
            winShift <= cfg.fineShift;
        end
    end

    // single register stage
    always_ff @(posedge clk) begin
        binEvent.bin      <= nextBin;
        binEvent.inWindow <= nextIn;
        if (!rstN) begin
            binEvent.valid <= 1'b0;
        end else begin
            // strobes outside a pass never leave the filter
            binEvent.valid <= wrEn && inPass;
        end
    end

endmodule

// File: hdl/hisBuilderFSM.sv
`timescale 1ns/10ps

module hisBuilderFSM #(
    parameter int COUNT_WIDTH = 8
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   startPulse,
    input  ctrlPkg::hisCfg_t       cfg,
    input  histPkg::binEvent_t     binEvent,
    input  histPkg::binIdx_t       rdAddr,
    output logic [COUNT_WIDTH-1:0] rdCount,
    input  logic                   peakDone,
    input  logic                   resultDone,
    output histPkg::hisPhase_t     phase
);
    import histPkg::*;

    // one saturating counter per bin
    logic [COUNT_WIDTH-1:0] binCount [NUM_BINS];
    // events accepted in the current pass
    logic [15:0] evCount;
    logic        inPass;
    logic        accept;
    logic        lastEvent;
    logic        binHit;

    assign inPass = (phase == COARSE) || (phase == FINE);
    // an event landing in a peak phase is dropped
    assign accept = binEvent.valid && inPass;
    assign binHit = accept && binEvent.inWindow;

    // one extra bit so the compare cannot wrap
    assign lastEvent = ({1'b0, evCount} + 17'd1) >= {1'b0, cfg.acqLength};

    always_ff @(posedge clk) begin
        if (!rstN) begin
            phase   <= IDLE;
            evCount <= '0;
        end else begin
            case (phase)
                IDLE: begin
                    if (startPulse) begin
                        phase   <= COARSE;
                        evCount <= '0;
                    end
                end
                COARSE: begin
                    if (accept) begin
                        evCount <= evCount + 16'd1;
                        if (lastEvent) begin
                            phase <= COARSE_PEAK;
                        end
                    end
                end
                COARSE_PEAK: begin
                    // fine pass counts from zero again
                    if (peakDone) begin
                        phase   <= FINE;
                        evCount <= '0;
                    end
                end
                FINE: begin
                    // out-of-window events still use up the quota
                    if (accept) begin
                        evCount <= evCount + 16'd1;
                        if (lastEvent) begin
                            phase <= FINE_PEAK;
                        end
                    end
                end
                FINE_PEAK: begin
                    if (peakDone) begin
                        phase <= DONE;
                    end
                end
                DONE: begin
                    // held here until the result is taken
                    if (resultDone) begin
                        phase <= IDLE;
                    end
                end
                default: begin
                    phase <= IDLE;
                end
            endcase
        end
    end

    // bin counters, cleared once the sweep has read them
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_BINS; i++) begin
            if (!rstN || peakDone) begin
                binCount[i] <= '0;
            end else if (binHit && (binEvent.bin == binIdx_t'(i))) begin
                // stick at all ones
                if (binCount[i] != '1) begin
                    binCount[i] <= binCount[i] + 1'b1;
                end
            end
        end
    end

    // detector read port, no latency
    assign rdCount = binCount[rdAddr];

endmodule

// File: hdl/peakDetecter.sv
`timescale 1ns/10ps

module peakDetecter #(
    parameter int COUNT_WIDTH = 8
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  histPkg::hisPhase_t     phase,
    input  logic [COUNT_WIDTH-1:0] rdCount,
    output histPkg::binIdx_t       rdAddr,
    output histPkg::binIdx_t       peakBin,
    output logic [COUNT_WIDTH-1:0] peakCount,
    output logic                   peakDone
);
    import histPkg::*;

    localparam binIdx_t LAST_BIN = binIdx_t'(NUM_BINS - 1);

    logic inPeak;
    // all 16 bins read for this phase
    logic swept;
    logic reading;

    assign inPeak  = (phase == COARSE_PEAK) || (phase == FINE_PEAK);
    // reads start in the first cycle of the peak phase
    assign reading = inPeak && !swept;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            rdAddr   <= '0;
            swept    <= 1'b0;
            peakDone <= 1'b0;
        end else begin
            // high the cycle after address 15 is read
            peakDone <= reading && (rdAddr == LAST_BIN);
            if (reading) begin
                // wraps back to 0 after the last bin
                rdAddr <= rdAddr + 1'b1;
                if (rdAddr == LAST_BIN) begin
                    swept <= 1'b1;
                end
            end else if (!inPeak) begin
                swept  <= 1'b0;
                rdAddr <= '0;
            end
        end
    end

    // running maximum, final once peakDone is up
    always_ff @(posedge clk) begin
        if (reading) begin
            // first read seeds the max
            // strict compare keeps the lowest bin on a tie
            if ((rdAddr == '0) || (rdCount > peakCount)) begin
                peakCount <= rdCount;
                peakBin   <= rdAddr;
            end
        end
    end

endmodule

// File: hdl/resultPort.sv
`timescale 1ns/10ps

module resultPort #(
    parameter int COUNT_WIDTH = 8
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  histPkg::hisPhase_t     phase,
    input  logic                   peakDone,
    input  histPkg::binIdx_t       peakBin,
    input  logic [COUNT_WIDTH-1:0] peakCount,
    input  ctrlPkg::hisCfg_t       cfg,
    output logic                   resultReq,
    input  logic                   resultAck,
    output histPkg::hisResult_t    result,
    output logic                   resultDone
);
    import histPkg::*;

    ts_t         thMinus;
    logic [15:0] binWidth;
    logic [15:0] halfWidth;
    logic [15:0] peakTime;
    logic        fineLatch;
    // req dropped, waiting for ack to fall
    logic        ackWait;

    assign fineLatch = peakDone && (phase == FINE_PEAK);

    // window edge from the stored coarse peak
    assign thMinus   = ts_t'({result.coarsePeak, {COARSE_SHIFT{1'b0}}});
    assign binWidth  = 16'd1 << cfg.fineShift;
    // zero at shift 0
    assign halfWidth = binWidth >> 1;
    // centre of the fine peak bin
    assign peakTime  = 16'(thMinus) + (16'(peakBin) << cfg.fineShift) + halfWidth;

    always_ff @(posedge clk) begin
        if (peakDone && (phase == COARSE_PEAK)) begin
            result.coarsePeak <= peakBin;
        end
        if (fineLatch) begin
            result.finePeak  <= peakBin;
            result.fineCount <= 16'(peakCount);
            result.peakTime  <= peakTime;
        end
    end

    // master side of four-phase
    always_ff @(posedge clk) begin
        if (!rstN) begin
            resultReq  <= 1'b0;
            ackWait    <= 1'b0;
            resultDone <= 1'b0;
        end else begin
            resultDone <= 1'b0;
            if (fineLatch) begin
                resultReq <= 1'b1;
            end else if (resultReq && resultAck) begin
                resultReq <= 1'b0;
                ackWait   <= 1'b1;
            end else if (ackWait && !resultAck) begin
                // slave done, builder may go idle
                ackWait    <= 1'b0;
                resultDone <= 1'b1;
            end
        end
    end

endmodule

// File: hdl/hisTop.sv
`timescale 1ns/10ps

module hisTop #(
    parameter int COUNT_WIDTH = 8
) (
    input  logic                clk,
    input  logic                rstN,
    input  histPkg::ts_t        roughData,
    input  logic                wrEn,
    input  logic                cfgReq,
    input  ctrlPkg::cfgWrite_t  cfgWord,
    output logic                cfgAck,
    output logic                resultReq,
    output histPkg::hisResult_t result,
    input  logic                resultAck,
    output histPkg::hisPhase_t  phase
);
    import histPkg::*;
    import ctrlPkg::*;

    hisCfg_t                cfg;
    logic                   startPulse;
    binEvent_t              binEvent;
    // detector to counter array
    binIdx_t                rdAddr;
    logic [COUNT_WIDTH-1:0] rdCount;
    binIdx_t                peakBin;
    logic [COUNT_WIDTH-1:0] peakCount;
    logic                   peakDone;
    logic                   resultDone;

    hisConfig u_config (
        .clk        (clk),
        .rstN       (rstN),
        .cfgReq     (cfgReq),
        .cfgWord    (cfgWord),
        .cfgAck     (cfgAck),
        .cfg        (cfg),
        .startPulse (startPulse)
    );

    dataFilter u_filter (
        .clk       (clk),
        .rstN      (rstN),
        .roughData (roughData),
        .wrEn      (wrEn),
        .phase     (phase),
        .cfg       (cfg),
        .peakBin   (peakBin),
        .peakDone  (peakDone),
        .binEvent  (binEvent)
    );

    hisBuilderFSM #(.COUNT_WIDTH(COUNT_WIDTH)) u_builder (
        .clk        (clk),
        .rstN       (rstN),
        .startPulse (startPulse),
        .cfg        (cfg),
        .binEvent   (binEvent),
        .rdAddr     (rdAddr),
        .rdCount    (rdCount),
        .peakDone   (peakDone),
        .resultDone (resultDone),
        .phase      (phase)
    );

    peakDetecter #(.COUNT_WIDTH(COUNT_WIDTH)) u_peak (
        .clk       (clk),
        .rstN      (rstN),
        .phase     (phase),
        .rdCount   (rdCount),
        .rdAddr    (rdAddr),
        .peakBin   (peakBin),
        .peakCount (peakCount),
        .peakDone  (peakDone)
    );

    resultPort #(.COUNT_WIDTH(COUNT_WIDTH)) u_result (
        .clk        (clk),
        .rstN       (rstN),
        .phase      (phase),
        .peakDone   (peakDone),
        .peakBin    (peakBin),
        .peakCount  (peakCount),
        .cfg        (cfg),
        .resultReq  (resultReq),
        .resultAck  (resultAck),
        .result     (result),
        .resultDone (resultDone)
    );

endmodule

// File: bench/clockGen.sv
`timescale 1ns/10ps

module clockGen (
    output logic clk
);
    // 8 ns period
    localparam time HALF_PERIOD = 4ns;

    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD) clk = ~clk;

endmodule

// File: bench/hisTopTb.sv
`timescale 1ns/10ps

module hisTopTb;
    import histPkg::*;
    import ctrlPkg::*;

    localparam int COUNT_WIDTH = 8;
    localparam int MAX_COUNT = (1 << COUNT_WIDTH) - 1;

    logic       clk;
    logic       rstN;
    ts_t        roughData;
    logic       wrEn;
    logic       cfgReq;
    cfgWrite_t  cfgWord;
    logic       cfgAck;
    logic       resultReq;
    hisResult_t result;
    logic       resultAck;
    hisPhase_t  phase;

    // reference histogram of the current pass
    int unsigned modelCount [16];
    logic [31:0] lcgState;
    string       testName;
    int          testErrors;
    int          errorCount;
    int          testCount;
    int          failCount;

    clockGen u_clk (
        .clk (clk)
    );

    hisTop #(.COUNT_WIDTH(COUNT_WIDTH)) u_dut (
        .clk       (clk),
        .rstN      (rstN),
        .roughData (roughData),
        .wrEn      (wrEn),
        .cfgReq    (cfgReq),
        .cfgWord   (cfgWord),
        .cfgAck    (cfgAck),
        .resultReq (resultReq),
        .result    (result),
        .resultAck (resultAck),
        .phase     (phase)
    );

    // numerical recipes LCG
    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // draws from the upper LCG bits since the low ones cycle fast
    function automatic int unsigned randBelow(input int unsigned n);
        return (nextRand() >> 8) % n;
    endfunction

    // cluster around the target with one in four as flat noise
    function automatic int drawStamp(input int target, input int spread, input bit noisy);
        int t;
        if (noisy && (randBelow(4) == 0)) begin
            t = int'(randBelow(1024));
        end else begin
            t = target + int'(randBelow(spread)) - spread / 2;
        end
        if (t < 0) begin
            t = 0;
        end
        if (t > 1023) begin
            t = 1023;
        end
        return t;
    endfunction

    function automatic void clearModel();
        for (int i = 0; i < 16; i++) begin
            modelCount[i] = 0;
        end
    endfunction

    // counters stick at the top value
    function automatic void bumpBin(input int b);
        if (modelCount[b] < MAX_COUNT) begin
            modelCount[b]++;
        end
    endfunction

    function automatic void modelEvent(input int ts, input bit fine, input int th, input int fs);
        if (!fine) begin
            // 64 ticks per coarse bin
            bumpBin(ts / 64);
        end else if ((ts >= th) && ((ts - th) < (16 << fs))) begin
            bumpBin((ts - th) >> fs);
        end
    endfunction

    // first strictly larger count wins
    function automatic void findPeak(output int bin, output int count);
        bin = 0;
        count = int'(modelCount[0]);
        for (int i = 1; i < 16; i++) begin
            if (int'(modelCount[i]) > count) begin
                bin = i;
                count = int'(modelCount[i]);
            end
        end
    endfunction

    task automatic checkValue(input string what, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (expected !== actual) begin
            errorCount++;
            $display("error %s %s expected %0h actual %0h", testName, what, expected, actual);
        end
    endtask

    task automatic abortRun(input string why);
        $display("%s in test %s", why, testName);
        $display("SIMULATION FAILED");
        $finish;
    endtask

    task automatic beginTest(input string name);
        testName = name;
        testErrors = errorCount;
    endtask

    task automatic endTest();
        testCount++;
        if (errorCount == testErrors) begin
            $display("test %s ok", testName);
        end else begin
            failCount++;
            $display("test %s failed, %0d errors", testName, errorCount - testErrors);
        end
    endtask

    task automatic waitPhase(input hisPhase_t target, input int limit, input string what);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while ((phase != target) && (cycles < limit));
        if (phase != target) begin
            abortRun({"timed out waiting for ", what});
        end
    endtask

    // master side of the four-phase write
    task automatic writeReg(input logic [1:0] addr, input logic [15:0] data);
        int cycles;
        @(posedge clk);
        cfgWord.addr <= addr;
        cfgWord.data <= data;
        cfgReq <= 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!cfgAck && (cycles < 10));
        if (!cfgAck) begin
            abortRun("cfgAck never rose after cfgReq");
        end
        @(posedge clk);
        cfgReq <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (cfgAck && (cycles < 10));
        if (cfgAck) begin
            abortRun("cfgAck stayed high after cfgReq dropped");
        end
    endtask

    // strobes with 0 to 3 idle cycles in front of each
    task automatic sendPass(input int n, input int target, input int spread, input bit noisy,
                            input bit fine, input int th, input int fs);
        int ts;
        int gap;
        for (int i = 0; i < n; i++) begin
            ts = drawStamp(target, spread, noisy);
            gap = int'(randBelow(4));
            repeat (gap) begin
                @(posedge clk);
                wrEn <= 1'b0;
            end
            @(posedge clk);
            wrEn <= 1'b1;
            roughData <= ts_t'(ts);
            modelEvent(ts, fine, th, fs);
        end
        @(posedge clk);
        wrEn <= 1'b0;
    endtask

    // slave stalls while stray strobes should be dropped
    task automatic holdResult(input int cycles, input hisResult_t expResult);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            wrEn <= (randBelow(2) == 1);
            roughData <= ts_t'(randBelow(1024));
            @(negedge clk);
            checkValue("result held", 64'(expResult), 64'(result));
            checkValue("resultReq held", 64'(1), 64'(resultReq));
            checkValue("phase held", 64'(DONE), 64'(phase));
        end
        @(posedge clk);
        wrEn <= 1'b0;
    endtask

    task automatic ackResult();
        int cycles;
        @(posedge clk);
        resultAck <= 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (resultReq && (cycles < 10));
        if (resultReq) begin
            abortRun("resultReq stayed high after resultAck");
        end
        @(posedge clk);
        resultAck <= 1'b0;
        waitPhase(IDLE, 10, "return to IDLE");
    endtask

    // one full acquisition over both passes against the model
    task automatic runAcq(input int len, input int fs, input bit fixedStamp,
                          input bit splitCoarse, input int ackDelay);
        int target;
        int spread;
        bit noisy;
        int expCoarse;
        int coarseCount;
        int expFine;
        int expCount;
        int th;
        int expTime;
        int cycles;
        hisResult_t expResult;
        target = int'(randBelow(1024));
        spread = fixedStamp ? 1 : (16 << fs) + 16;
        noisy = !fixedStamp;
        writeReg(REG_ACQ_LEN, 16'(len));
        writeReg(REG_FINE_SHIFT, 16'(fs));
        writeReg(REG_START, 16'd0);
        waitPhase(COARSE, 10, "coarse pass");
        clearModel();
        if (splitCoarse) begin
            // one short of acqLength keeps the pass open
            sendPass(len - 1, target, spread, noisy, 1'b0, 0, fs);
            repeat (4) @(negedge clk);
            checkValue("phase one event short", 64'(COARSE), 64'(phase));
            sendPass(1, target, spread, noisy, 1'b0, 0, fs);
        end else begin
            sendPass(len, target, spread, noisy, 1'b0, 0, fs);
        end
        findPeak(expCoarse, coarseCount);
        waitPhase(FINE, 50, "fine pass");
        th = expCoarse * 64;
        clearModel();
        sendPass(len, target, spread, noisy, 1'b1, th, fs);
        findPeak(expFine, expCount);
        // centre of the fine bin with no half step at width 1
        expTime = th + (expFine << fs) + ((1 << fs) >> 1);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!resultReq && (cycles < 50));
        if (!resultReq) begin
            abortRun("resultReq never rose after the fine pass");
        end
        checkValue("coarsePeak", 64'(expCoarse), 64'(result.coarsePeak));
        checkValue("finePeak", 64'(expFine), 64'(result.finePeak));
        checkValue("fineCount", 64'(expCount), 64'(result.fineCount));
        checkValue("peakTime", 64'(expTime), 64'(result.peakTime));
        checkValue("phase at result", 64'(DONE), 64'(phase));
        expResult.coarsePeak = binIdx_t'(expCoarse);
        expResult.finePeak = binIdx_t'(expFine);
        expResult.fineCount = 16'(expCount);
        expResult.peakTime = 16'(expTime);
        if (ackDelay > 0) begin
            holdResult(ackDelay, expResult);
        end
        ackResult();
    endtask

    initial begin
        rstN = 1'b0;
        roughData = '0;
        wrEn = 1'b0;
        cfgReq = 1'b0;
        cfgWord = '0;
        resultAck = 1'b0;
        lcgState = 32'hbd6a_fb31;
        errorCount = 0;
        testCount = 0;
        failCount = 0;
        testName = "reset";
        repeat (10) @(posedge clk);
        rstN <= 1'b1;

        beginTest("reset");
        @(negedge clk);
        checkValue("cfgAck", 64'(0), 64'(cfgAck));
        checkValue("resultReq", 64'(0), 64'(resultReq));
        checkValue("phase", 64'(IDLE), 64'(phase));
        endTest();

        beginTest("config write");
        runAcq(20, 0, 1'b0, 1'b1, 0);
        endTest();

        beginTest("random acquisitions");
        for (int i = 0; i < 4; i++) begin
            runAcq(24 + int'(randBelow(40)), (i % 2) * 2, 1'b0, 1'b0, 0);
        end
        endTest();

        beginTest("saturation");
        runAcq(300, 2, 1'b1, 1'b0, 0);
        endTest();

        beginTest("result back-pressure");
        runAcq(32, 2, 1'b0, 1'b0, 8 + int'(randBelow(32)));
        runAcq(40, 0, 1'b0, 1'b0, 0);
        endTest();

        $display("tests %0d, failed %0d, errors %0d", testCount, failCount, errorCount);
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
hdl/histPkg.sv
hdl/ctrlPkg.sv
hdl/hisConfig.sv
hdl/dataFilter.sv
hdl/hisBuilderFSM.sv
hdl/peakDetecter.sv
hdl/resultPort.sv
hdl/hisTop.sv
bench/clockGen.sv
bench/hisTopTb.sv

// File: run.sh
#!/usr/bin/env bash
# compile the testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f files.f --top-module hisTopTb \
    && ./obj_dir/VhisTopTb | tee /dev/stderr | grep -qF "SIMULATION PASSED" \
    && echo "run ok" \
    || { echo "run not ok"; exit 1; }
